//--- rtl/isa_pkg.sv
// RV64I/M encodings for OP, OP-IMM and LUI only; no W forms, loads, stores or branches
package isa_pkg;

	localparam int ILEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int REG_COUNT  = 32;

	// major opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;

	// base integer funct3
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// M extension funct3, only with F7_MULDIV
	localparam logic [2:0] F3_MUL   = 3'b000;
	localparam logic [2:0] F3_MULHU = 3'b011;
	localparam logic [2:0] F3_DIV   = 3'b100;
	localparam logic [2:0] F3_DIVU  = 3'b101;
	localparam logic [2:0] F3_REM   = 3'b110;
	localparam logic [2:0] F3_REMU  = 3'b111;

	localparam logic [6:0] F7_BASE   = 7'b0000000;
	localparam logic [6:0] F7_ALT    = 7'b0100000; // sub, sra
	localparam logic [6:0] F7_MULDIV = 7'b0000001;

	// imm[11:6] of the 64-bit immediate shifts
	localparam logic [5:0] F6_SHL_SRL = 6'b000000;
	localparam logic [5:0] F6_SRA     = 6'b010000;

	// one instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [6:0]            funct7;
			logic [REG_ADDR_W-1:0] rs2;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0]            funct3;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0]            opcode;
		} r_fmt;
		struct packed {
			logic [11:0]           imm12;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0]            funct3;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0]            opcode;
		} i_fmt;
		struct packed {
			logic [19:0]           imm20;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0]            opcode;
		} u_fmt;
	} instr_u;

endpackage

//--- rtl/alu_pkg.sv
// ALU control encoding; the control word is one-hot, bit positions must match alu.sv order
package alu_pkg;

	localparam int XLEN    = 64;
	localparam int SHAMT_W = 6; // low bits of src2 used as shift amount
	localparam int ALU_OPS = 17;

	// control word bit positions
	localparam int OP_ADD   = 0;
	localparam int OP_SUB   = 1;
	localparam int OP_SLT   = 2;
	localparam int OP_SLTU  = 3;
	localparam int OP_AND   = 4;
	localparam int OP_OR    = 5;
	localparam int OP_XOR   = 6;
	localparam int OP_SLL   = 7;
	localparam int OP_SRL   = 8;
	localparam int OP_SRA   = 9;
	localparam int OP_LUI   = 10;
	localparam int OP_MUL   = 11;
	localparam int OP_DIV   = 12;
	localparam int OP_REM   = 13;
	localparam int OP_MULHU = 14; // upper half of unsigned product
	localparam int OP_DIVU  = 15;
	localparam int OP_REMU  = 16;

endpackage

//--- rtl/alu.sv
// combinational 64-bit ALU; control must be one-hot or zero, divide follows RISC-V corner rules
`timescale 1ns/1ps

module alu (
	input  logic [alu_pkg::ALU_OPS-1:0] alu_control,
	input  logic [alu_pkg::XLEN-1:0]    alu_src1,
	input  logic [alu_pkg::XLEN-1:0]    alu_src2,
	output logic [alu_pkg::XLEN-1:0]    alu_result
);

	localparam int W = alu_pkg::XLEN;

	logic op_add, op_sub, op_slt, op_sltu;
	logic op_and, op_or, op_xor;
	logic op_sll, op_srl, op_sra, op_lui;
	logic op_mul, op_div, op_rem, op_mulhu, op_divu, op_remu;

	assign op_add   = alu_control[alu_pkg::OP_ADD];
	assign op_sub   = alu_control[alu_pkg::OP_SUB];
	assign op_slt   = alu_control[alu_pkg::OP_SLT];
	assign op_sltu  = alu_control[alu_pkg::OP_SLTU];
	assign op_and   = alu_control[alu_pkg::OP_AND];
	assign op_or    = alu_control[alu_pkg::OP_OR];
	assign op_xor   = alu_control[alu_pkg::OP_XOR];
	assign op_sll   = alu_control[alu_pkg::OP_SLL];
	assign op_srl   = alu_control[alu_pkg::OP_SRL];
	assign op_sra   = alu_control[alu_pkg::OP_SRA];
	assign op_lui   = alu_control[alu_pkg::OP_LUI];
	assign op_mul   = alu_control[alu_pkg::OP_MUL];
	assign op_div   = alu_control[alu_pkg::OP_DIV];
	assign op_rem   = alu_control[alu_pkg::OP_REM];
	assign op_mulhu = alu_control[alu_pkg::OP_MULHU];
	assign op_divu  = alu_control[alu_pkg::OP_DIVU];
	assign op_remu  = alu_control[alu_pkg::OP_REMU];

	// shared adder, subtract and compares use src1 + ~src2 + 1
	logic         adder_inv;
	logic [W-1:0] adder_b;
	logic [W-1:0] adder_sum;
	logic         adder_cout;

	assign adder_inv = op_sub | op_slt | op_sltu;
	assign adder_b   = adder_inv ? ~alu_src2 : alu_src2;
	assign {adder_cout, adder_sum} = {1'b0, alu_src1} + {1'b0, adder_b} + {{W{1'b0}}, adder_inv};

	logic slt_bit;
	logic sltu_bit;

	// signs differ: src1 negative wins; same sign: look at the difference
	assign slt_bit  = (alu_src1[W-1] & ~alu_src2[W-1])
			| (~(alu_src1[W-1] ^ alu_src2[W-1]) & adder_sum[W-1]);
	assign sltu_bit = ~adder_cout; // borrow out

	logic [alu_pkg::SHAMT_W-1:0] shamt;
	logic [W-1:0]                sll_result, srl_result, sra_result;

	assign shamt      = alu_src2[alu_pkg::SHAMT_W-1:0];
	assign sll_result = alu_src1 << shamt;
	assign srl_result = alu_src1 >> shamt;
	assign sra_result = $signed(alu_src1) >>> shamt;

	// one unsigned multiplier, low half is the same for signed mul
	logic [2*W-1:0] product;

	assign product = {{W{1'b0}}, alu_src1} * {{W{1'b0}}, alu_src2};

	// divide; a divisor of 1 in the overflow case yields min and remainder 0 directly
	logic         div_zero;
	logic         div_ovf;
	logic [W-1:0] divisor_s, divisor_u;
	logic [W-1:0] quot_s, rem_s, quot_u, rem_u;

	assign div_zero  = (alu_src2 == '0);
	assign div_ovf   = (alu_src1 == {1'b1, {(W-1){1'b0}}}) && (alu_src2 == '1);
	assign divisor_s = (div_zero | div_ovf) ? W'(1) : alu_src2;
	assign divisor_u = div_zero ? W'(1) : alu_src2;

	assign quot_s = $signed(alu_src1) / $signed(divisor_s);
	assign rem_s  = $signed(alu_src1) % $signed(divisor_s);
	assign quot_u = alu_src1 / divisor_u;
	assign rem_u  = alu_src1 % divisor_u;

	logic [W-1:0] div_result, rem_result, divu_result, remu_result;

	assign div_result  = div_zero ? '1 : quot_s;
	assign rem_result  = div_zero ? alu_src1 : rem_s;
	assign divu_result = div_zero ? '1 : quot_u;
	assign remu_result = div_zero ? alu_src1 : rem_u;

	assign alu_result = ({W{op_add | op_sub}} & adder_sum)
			| ({W{op_slt}}   & {{(W-1){1'b0}}, slt_bit})
			| ({W{op_sltu}}  & {{(W-1){1'b0}}, sltu_bit})
			| ({W{op_and}}   & (alu_src1 & alu_src2))
			| ({W{op_or}}    & (alu_src1 | alu_src2))
			| ({W{op_xor}}   & (alu_src1 ^ alu_src2))
			| ({W{op_sll}}   & sll_result)
			| ({W{op_srl}}   & srl_result)
			| ({W{op_sra}}   & sra_result)
			| ({W{op_lui}}   & alu_src2)
			| ({W{op_mul}}   & product[W-1:0])
			| ({W{op_mulhu}} & product[2*W-1:W])
			| ({W{op_div}}   & div_result)
			| ({W{op_rem}}   & rem_result)
			| ({W{op_divu}}  & divu_result)
			| ({W{op_remu}}  & remu_result);

endmodule

//--- rtl/instr_decode.sv
// decodes OP, OP-IMM and LUI only; anything else is illegal with a zero control word
`timescale 1ns/1ps

module instr_decode (
	input  isa_pkg::instr_u                    instr,
	output logic [isa_pkg::REG_ADDR_W-1:0]     rs1_addr,
	output logic [isa_pkg::REG_ADDR_W-1:0]     rs2_addr,
	output logic [isa_pkg::REG_ADDR_W-1:0]     rd,
	output logic [alu_pkg::XLEN-1:0]           imm,
	output logic                               use_imm,
	output logic [alu_pkg::ALU_OPS-1:0]        alu_control,
	output logic                               legal
);

	localparam int W = alu_pkg::XLEN;

	logic [W-1:0]                imm_i;
	logic [W-1:0]                imm_u;
	logic [W-1:0]                imm_sh;
	logic [11-alu_pkg::SHAMT_W:0] imm_hi; // imm[11:6] of a shift
	logic [6:0]                  funct7;
	logic [2:0]                  funct3;

	assign rs1_addr = instr.r_fmt.rs1;
	assign rs2_addr = instr.r_fmt.rs2;
	assign rd       = instr.r_fmt.rd;
	assign funct7   = instr.r_fmt.funct7;
	assign funct3   = instr.i_fmt.funct3;

	assign imm_i  = {{(W-12){instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
	assign imm_u  = {{(W-32){instr.u_fmt.imm20[19]}}, instr.u_fmt.imm20, 12'b0};
	assign imm_sh = {{(W-alu_pkg::SHAMT_W){1'b0}}, instr.i_fmt.imm12[alu_pkg::SHAMT_W-1:0]};
	assign imm_hi = instr.i_fmt.imm12[11:alu_pkg::SHAMT_W];

	always_comb begin
		alu_control = '0;
		legal       = 1'b0;
		use_imm     = 1'b0;
		imm         = '0;
		case (instr.r_fmt.opcode)
			isa_pkg::OPC_OP: begin
				legal = 1'b1; // cleared below for unlisted codes
				if (funct7 == isa_pkg::F7_BASE) begin
					case (funct3)
						isa_pkg::F3_ADD_SUB: alu_control[alu_pkg::OP_ADD]  = 1'b1;
						isa_pkg::F3_SLL:     alu_control[alu_pkg::OP_SLL]  = 1'b1;
						isa_pkg::F3_SLT:     alu_control[alu_pkg::OP_SLT]  = 1'b1;
						isa_pkg::F3_SLTU:    alu_control[alu_pkg::OP_SLTU] = 1'b1;
						isa_pkg::F3_XOR:     alu_control[alu_pkg::OP_XOR]  = 1'b1;
						isa_pkg::F3_SRL_SRA: alu_control[alu_pkg::OP_SRL]  = 1'b1;
						isa_pkg::F3_OR:      alu_control[alu_pkg::OP_OR]   = 1'b1;
						default:             alu_control[alu_pkg::OP_AND]  = 1'b1;
					endcase
				end else if (funct7 == isa_pkg::F7_ALT && funct3 == isa_pkg::F3_ADD_SUB) begin
					alu_control[alu_pkg::OP_SUB] = 1'b1;
				end else if (funct7 == isa_pkg::F7_ALT && funct3 == isa_pkg::F3_SRL_SRA) begin
					alu_control[alu_pkg::OP_SRA] = 1'b1;
				end else if (funct7 == isa_pkg::F7_MULDIV) begin
					case (funct3)
						isa_pkg::F3_MUL:   alu_control[alu_pkg::OP_MUL]   = 1'b1;
						isa_pkg::F3_MULHU: alu_control[alu_pkg::OP_MULHU] = 1'b1;
						isa_pkg::F3_DIV:   alu_control[alu_pkg::OP_DIV]   = 1'b1;
						isa_pkg::F3_DIVU:  alu_control[alu_pkg::OP_DIVU]  = 1'b1;
						isa_pkg::F3_REM:   alu_control[alu_pkg::OP_REM]   = 1'b1;
						isa_pkg::F3_REMU:  alu_control[alu_pkg::OP_REMU]  = 1'b1;
						default:           legal = 1'b0; // mulh, mulhsu
					endcase
				end else begin
					legal = 1'b0;
				end
			end
			isa_pkg::OPC_OP_IMM: begin
				legal   = 1'b1;
				use_imm = 1'b1;
				imm     = imm_i;
				case (funct3)
					isa_pkg::F3_ADD_SUB: alu_control[alu_pkg::OP_ADD]  = 1'b1;
					isa_pkg::F3_SLT:     alu_control[alu_pkg::OP_SLT]  = 1'b1;
					isa_pkg::F3_SLTU:    alu_control[alu_pkg::OP_SLTU] = 1'b1;
					isa_pkg::F3_XOR:     alu_control[alu_pkg::OP_XOR]  = 1'b1;
					isa_pkg::F3_OR:      alu_control[alu_pkg::OP_OR]   = 1'b1;
					isa_pkg::F3_AND:     alu_control[alu_pkg::OP_AND]  = 1'b1;
					isa_pkg::F3_SLL: begin
						imm = imm_sh;
						if (imm_hi == isa_pkg::F6_SHL_SRL)
							alu_control[alu_pkg::OP_SLL] = 1'b1;
						else
							legal = 1'b0;
					end
					default: begin // srli / srai
						imm = imm_sh;
						if (imm_hi == isa_pkg::F6_SHL_SRL)
							alu_control[alu_pkg::OP_SRL] = 1'b1;
						else if (imm_hi == isa_pkg::F6_SRA)
							alu_control[alu_pkg::OP_SRA] = 1'b1;
						else
							legal = 1'b0;
					end
				endcase
			end
			isa_pkg::OPC_LUI: begin
				legal   = 1'b1;
				use_imm = 1'b1;
				imm     = imm_u;
				alu_control[alu_pkg::OP_LUI] = 1'b1;
			end
			default: legal = 1'b0;
		endcase
		if (!legal)
			alu_control = '0;
	end

endmodule

//--- rtl/reg_file.sv
// 32 x 64 integer registers; combinational reads, write lands on the clock edge, x0 reads zero
`timescale 1ns/1ps

module reg_file (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [isa_pkg::REG_ADDR_W-1:0] rs1_addr,
	input  logic [isa_pkg::REG_ADDR_W-1:0] rs2_addr,
	output logic [alu_pkg::XLEN-1:0]       rs1_data,
	output logic [alu_pkg::XLEN-1:0]       rs2_data,
	input  logic                           we,
	input  logic [isa_pkg::REG_ADDR_W-1:0] waddr,
	input  logic [alu_pkg::XLEN-1:0]       wdata
);

	logic [alu_pkg::XLEN-1:0] regs [isa_pkg::REG_COUNT];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < isa_pkg::REG_COUNT; i++)
				regs[i] <= '0;
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// no bypass, a write is visible from the next cycle on
	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- rtl/exec_unit.sv
// one-cycle execute stage; no back-pressure, results and illegal flags are single-cycle pulses
`timescale 1ns/1ps

module exec_unit (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [isa_pkg::ILEN-1:0]       instr,
	input  logic                           instr_valid,
	output logic [alu_pkg::XLEN-1:0]       result,
	output logic [isa_pkg::REG_ADDR_W-1:0] result_rd,
	output logic                           result_valid,
	output logic                           illegal
);

	isa_pkg::instr_u                 instr_word;
	logic [isa_pkg::REG_ADDR_W-1:0]  rs1_addr, rs2_addr, rd;
	logic [alu_pkg::XLEN-1:0]        imm;
	logic                            use_imm;
	logic [alu_pkg::ALU_OPS-1:0]     alu_control;
	logic                            legal;
	logic [alu_pkg::XLEN-1:0]        rs1_data, rs2_data;
	logic [alu_pkg::XLEN-1:0]        alu_src1, alu_src2, alu_result;
	logic                            wr_en;

	assign instr_word = instr;

	instr_decode instr_decode_inst (
		.instr       (instr_word),
		.rs1_addr    (rs1_addr),
		.rs2_addr    (rs2_addr),
		.rd          (rd),
		.imm         (imm),
		.use_imm     (use_imm),
		.alu_control (alu_control),
		.legal       (legal)
	);

	assign wr_en = instr_valid & legal;

	reg_file reg_file_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.we       (wr_en),
		.waddr    (rd),
		.wdata    (alu_result)
	);

	assign alu_src1 = rs1_data;
	assign alu_src2 = use_imm ? imm : rs2_data; // lui imm already shifted

	alu alu_inst (
		.alu_control (alu_control),
		.alu_src1    (alu_src1),
		.alu_src2    (alu_src2),
		.alu_result  (alu_result)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result       <= '0;
			result_rd    <= '0;
			result_valid <= 1'b0;
			illegal      <= 1'b0;
		end else begin
			result_valid <= wr_en;
			illegal      <= instr_valid & ~legal;
			if (wr_en) begin // rd = x0 still reported
				result    <= alu_result;
				result_rd <= rd;
			end
		end
	end

endmodule

//--- tests/exec_ref.svh
// include inside the testbench module; encoders plus a 64-bit result model for OP, OP-IMM and LUI
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

logic [63:0] model_regs [isa_pkg::REG_COUNT]; // mirrors the architectural registers

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
		input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, isa_pkg::OPC_OP};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm12, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd);
	return {imm12, rs1, f3, rd, isa_pkg::OPC_OP_IMM};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm20, input logic [4:0] rd);
	return {imm20, rd, isa_pkg::OPC_LUI};
endfunction

// f7 picks sub, sra or the M extension, as in the instruction word
function automatic logic [63:0] ref_alu(input logic [6:0] f7, input logic [2:0] f3,
		input logic [63:0] a, b);
	logic [127:0]       prod;
	logic signed [63:0] sa, sb, q, r;
	sa   = a;
	sb   = b;
	prod = {64'b0, a} * {64'b0, b};
	if (f7 == isa_pkg::F7_MULDIV) begin
		case (f3)
			isa_pkg::F3_MUL:   return prod[63:0];
			isa_pkg::F3_MULHU: return prod[127:64];
			isa_pkg::F3_DIVU:  return (b == '0) ? '1 : a / b;
			isa_pkg::F3_REMU:  return (b == '0) ? a : a % b;
			default: ;
		endcase
		// signed divide corner cases
		if (b == '0)
			return (f3 == isa_pkg::F3_DIV) ? '1 : a;
		if (a == 64'h8000_0000_0000_0000 && b == '1)
			return (f3 == isa_pkg::F3_DIV) ? a : '0;
		q = sa / sb;
		r = sa % sb;
		return (f3 == isa_pkg::F3_DIV) ? q : r;
	end
	case (f3)
		isa_pkg::F3_ADD_SUB: return (f7 == isa_pkg::F7_ALT) ? a - b : a + b;
		isa_pkg::F3_SLL:     return a << b[5:0];
		isa_pkg::F3_SLT:     return {63'b0, sa < sb};
		isa_pkg::F3_SLTU:    return {63'b0, a < b};
		isa_pkg::F3_XOR:     return a ^ b;
		isa_pkg::F3_SRL_SRA: begin
			if (f7 == isa_pkg::F7_ALT)
				return sa >>> b[5:0];
			return a >> b[5:0];
		end
		isa_pkg::F3_OR:      return a | b;
		default:             return a & b;
	endcase
endfunction

`endif

//--- tests/exec_unit_tb.sv
// directed tests of exec_unit with a one-cycle latency model; needs tests/ on the include path
`timescale 1ns/1ps

module exec_unit_tb;

	localparam int PERIOD = 40;
	// instructions per test: reset, alu ops, shifts, muldiv, illegal, chain (plus idle check)
	localparam int INSTR_COUNT = 8 + 4 * 37 + 11 + 5 * 7 + 4 * 28 + 7 + 9;

	logic        clk;
	logic        rst_n;
	logic [31:0] instr;
	logic        instr_valid;
	logic [63:0] result;
	logic [4:0]  result_rd;
	logic        result_valid;
	logic        illegal;

	int test_errors;
	int tests_passed;
	int tests_failed;
	int seed_state;

	`include "exec_ref.svh"

	exec_unit exec_unit_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr        (instr),
		.instr_valid  (instr_valid),
		.result       (result),
		.result_rd    (result_rd),
		.result_valid (result_valid),
		.illegal      (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		#((INSTR_COUNT + 20) * PERIOD);
		$display("watchdog expired before the tests finished");
		$display("** FAIL **");
		$finish;
	end

	task automatic expect_out(input logic ev, input logic ei, input logic [4:0] erd,
			input logic [63:0] exp_val);
		assert (result_valid === ev && illegal === ei) else begin
			$display("ERROR %0t: valid/illegal %b/%b, expected %b/%b",
				$time, result_valid, illegal, ev, ei);
			test_errors++;
		end
		if (ev) begin
			assert (result === exp_val && result_rd === erd) else begin
				$display("ERROR %0t: x%0d = %h, expected x%0d = %h",
					$time, result_rd, result, erd, exp_val);
				test_errors++;
			end
		end
	endtask

	// drive at the current drive point, check one edge later
	task automatic issue(input logic [31:0] word, input logic ok, input logic [4:0] rd,
			input logic [63:0] val);
		instr       = word;
		instr_valid = 1'b1;
		@(posedge clk);
		#2;
		instr_valid = 1'b0;
		expect_out(ok, ~ok, rd, val);
		if (ok && rd != '0)
			model_regs[rd] = val;
	endtask

	task automatic run_r(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
			input logic [4:0] rs1, rs2);
		issue(enc_r(f7, rs2, rs1, f3, rd), 1'b1, rd,
			ref_alu(f7, f3, model_regs[rs1], model_regs[rs2]));
	endtask

	task automatic run_i(input logic [2:0] f3, input logic [4:0] rd, rs1, input logic [11:0] imm);
		logic [6:0] f7;
		f7 = (f3 == isa_pkg::F3_SRL_SRA) ? {imm[11:6], 1'b0} : isa_pkg::F7_BASE;
		issue(enc_i(imm, rs1, f3, rd), 1'b1, rd,
			ref_alu(f7, f3, model_regs[rs1], {{52{imm[11]}}, imm}));
	endtask

	task automatic run_u(input logic [4:0] rd, input logic [19:0] imm);
		issue(enc_u(imm, rd), 1'b1, rd, {{32{imm[19]}}, imm, 12'b0});
	endtask

	// 9-bit top chunk, then five shift-and-or steps of 11 bits
	task automatic load_reg(input logic [4:0] rd, input logic [63:0] v);
		run_i(isa_pkg::F3_ADD_SUB, rd, 5'd0, {3'b0, v[63:55]});
		for (int k = 4; k >= 0; k--) begin
			run_i(isa_pkg::F3_SLL, rd, rd, 12'd11);
			run_i(isa_pkg::F3_OR, rd, rd, {1'b0, 11'(v >> (11 * k))});
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			$display("test %s passed", name);
			tests_passed++;
		end else begin
			$display("test %s failed with %0d errors", name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	task automatic test_reset_load();
		expect_out(1'b0, 1'b0, 5'd0, '0);
		assert (result === '0 && result_rd === '0) else begin
			$display("ERROR %0t: result %h rd %0d not cleared by reset", $time, result, result_rd);
			test_errors++;
		end
		run_u(5'd1, 20'h12345);
		run_i(isa_pkg::F3_ADD_SUB, 5'd2, 5'd1, 12'h678); // x1 written the cycle before
		run_u(5'd3, 20'h80000); // sign extends
		run_i(isa_pkg::F3_ADD_SUB, 5'd3, 5'd3, 12'hfff);
		run_i(isa_pkg::F3_ADD_SUB, 5'd0, 5'd2, 12'h005); // reported, not kept
		run_i(isa_pkg::F3_ADD_SUB, 5'd4, 5'd0, 12'h001);
		run_u(5'd0, 20'hfffff);
		run_r(isa_pkg::F7_BASE, isa_pkg::F3_OR, 5'd5, 5'd0, 5'd3);
		finish_test("reset and register load");
	endtask

	task automatic test_alu_ops();
		logic [63:0] a_vals [4];
		logic [63:0] b_vals [4];
		a_vals[0] = {$urandom, $urandom};
		b_vals[0] = {$urandom, $urandom};
		a_vals[1] = 64'h8000_0000_0000_0000; // signed and unsigned compare disagree
		b_vals[1] = 64'h1;
		a_vals[2] = 64'h7fff_ffff_ffff_ffff;
		b_vals[2] = '1;
		a_vals[3] = {$urandom, $urandom};
		b_vals[3] = a_vals[3];
		for (int k = 0; k < 4; k++) begin
			load_reg(5'd5, a_vals[k]);
			load_reg(5'd6, b_vals[k]);
			run_r(isa_pkg::F7_BASE, isa_pkg::F3_ADD_SUB, 5'd7, 5'd5, 5'd6);
			run_r(isa_pkg::F7_ALT, isa_pkg::F3_ADD_SUB, 5'd7, 5'd5, 5'd6);
			run_r(isa_pkg::F7_BASE, isa_pkg::F3_SLT, 5'd7, 5'd5, 5'd6);
			run_r(isa_pkg::F7_BASE, isa_pkg::F3_SLT, 5'd7, 5'd6, 5'd5);
			run_r(isa_pkg::F7_BASE, isa_pkg::F3_SLTU, 5'd7, 5'd5, 5'd6);
			run_r(isa_pkg::F7_BASE, isa_pkg::F3_SLTU, 5'd7, 5'd6, 5'd5);
			run_r(isa_pkg::F7_BASE, isa_pkg::F3_AND, 5'd7, 5'd5, 5'd6);
			run_r(isa_pkg::F7_BASE, isa_pkg::F3_OR, 5'd7, 5'd5, 5'd6);
			run_r(isa_pkg::F7_BASE, isa_pkg::F3_XOR, 5'd7, 5'd5, 5'd6);
			run_i(isa_pkg::F3_ADD_SUB, 5'd8, 5'd5, 12'($urandom));
			run_i(isa_pkg::F3_SLT, 5'd8, 5'd5, 12'($urandom));
			run_i(isa_pkg::F3_SLTU, 5'd8, 5'd5, 12'($urandom));
			run_i(isa_pkg::F3_XOR, 5'd8, 5'd5, 12'($urandom));
			run_i(isa_pkg::F3_OR, 5'd8, 5'd5, 12'($urandom));
			run_i(isa_pkg::F3_AND, 5'd8, 5'd5, 12'($urandom));
		end
		finish_test("arithmetic, logic and compare");
	endtask

	task automatic test_shifts();
		int amts [5];
		amts = '{0, 1, 31, 32, 63};
		load_reg(5'd7, {1'b1, 31'($urandom), $urandom});
		for (int k = 0; k < 5; k++) begin
			run_i(isa_pkg::F3_ADD_SUB, 5'd8, 5'd0, 12'(amts[k] + 64 * k)); // junk above bit 5
			run_r(isa_pkg::F7_BASE, isa_pkg::F3_SLL, 5'd9, 5'd7, 5'd8);
			run_r(isa_pkg::F7_BASE, isa_pkg::F3_SRL_SRA, 5'd9, 5'd7, 5'd8);
			run_r(isa_pkg::F7_ALT, isa_pkg::F3_SRL_SRA, 5'd9, 5'd7, 5'd8);
			run_i(isa_pkg::F3_SLL, 5'd10, 5'd7, {6'b0, 6'(amts[k])});
			run_i(isa_pkg::F3_SRL_SRA, 5'd10, 5'd7, {6'b0, 6'(amts[k])});
			run_i(isa_pkg::F3_SRL_SRA, 5'd10, 5'd7, {isa_pkg::F6_SRA, 6'(amts[k])});
		end
		finish_test("shifts");
	endtask

	task automatic test_muldiv();
		logic [63:0] a_vals [4];
		logic [63:0] b_vals [4];
		a_vals[0] = {$urandom, $urandom};
		b_vals[0] = {$urandom, $urandom};
		a_vals[1] = {$urandom, $urandom};
		b_vals[1] = '0; // divide by zero
		a_vals[2] = 64'h8000_0000_0000_0000;
		b_vals[2] = '1; // signed overflow
		a_vals[3] = {1'b1, 31'($urandom), $urandom};
		b_vals[3] = -64'(($urandom % 13) + 2);
		for (int k = 0; k < 4; k++) begin
			load_reg(5'd5, a_vals[k]);
			load_reg(5'd6, b_vals[k]);
			run_r(isa_pkg::F7_MULDIV, isa_pkg::F3_MUL, 5'd11, 5'd5, 5'd6);
			run_r(isa_pkg::F7_MULDIV, isa_pkg::F3_MULHU, 5'd11, 5'd5, 5'd6);
			run_r(isa_pkg::F7_MULDIV, isa_pkg::F3_DIV, 5'd11, 5'd5, 5'd6);
			run_r(isa_pkg::F7_MULDIV, isa_pkg::F3_DIVU, 5'd11, 5'd5, 5'd6);
			run_r(isa_pkg::F7_MULDIV, isa_pkg::F3_REM, 5'd11, 5'd5, 5'd6);
			run_r(isa_pkg::F7_MULDIV, isa_pkg::F3_REMU, 5'd11, 5'd5, 5'd6);
		end
		finish_test("multiply and divide");
	endtask

	task automatic test_illegal();
		run_i(isa_pkg::F3_ADD_SUB, 5'd11, 5'd0, 12'h155);
		issue({12'h0, 5'd0, 3'b011, 5'd11, 7'b0000011}, 1'b0, 5'd0, '0); // ld
		run_i(isa_pkg::F3_ADD_SUB, 5'd12, 5'd11, 12'h0);
		issue(enc_r(7'b0000100, 5'd1, 5'd2, isa_pkg::F3_ADD_SUB, 5'd11), 1'b0, 5'd0, '0);
		run_i(isa_pkg::F3_ADD_SUB, 5'd12, 5'd11, 12'h0);
		issue(enc_i({6'b110000, 6'd3}, 5'd2, isa_pkg::F3_SRL_SRA, 5'd11), 1'b0, 5'd0, '0);
		run_i(isa_pkg::F3_ADD_SUB, 5'd12, 5'd11, 12'h0);
		finish_test("illegal encodings");
	endtask

	task automatic test_back_to_back();
		run_i(isa_pkg::F3_ADD_SUB, 5'd13, 5'd0, 12'd7);
		run_r(isa_pkg::F7_BASE, isa_pkg::F3_ADD_SUB, 5'd13, 5'd13, 5'd13);
		run_i(isa_pkg::F3_SLL, 5'd13, 5'd13, 12'd3);
		run_r(isa_pkg::F7_ALT, isa_pkg::F3_ADD_SUB, 5'd14, 5'd13, 5'd1);
		run_r(isa_pkg::F7_MULDIV, isa_pkg::F3_MUL, 5'd14, 5'd14, 5'd13);
		run_r(isa_pkg::F7_BASE, isa_pkg::F3_XOR, 5'd13, 5'd14, 5'd2);
		run_r(isa_pkg::F7_MULDIV, isa_pkg::F3_DIV, 5'd14, 5'd14, 5'd13);
		run_r(isa_pkg::F7_ALT, isa_pkg::F3_SRL_SRA, 5'd15, 5'd13, 5'd14);
		@(posedge clk);
		#2;
		expect_out(1'b0, 1'b0, 5'd0, '0); // stream ended, pulse must drop
		finish_test("back-to-back issue");
	endtask

	initial begin
		seed_state   = $urandom(50);
		test_errors  = 0;
		tests_passed = 0;
		tests_failed = 0;
		rst_n        = 1'b0;
		instr        = '0;
		instr_valid  = 1'b0;
		for (int i = 0; i < isa_pkg::REG_COUNT; i++)
			model_regs[i] = '0;
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		test_reset_load();
		test_alu_ops();
		test_shifts();
		test_muldiv();
		test_illegal();
		test_back_to_back();
		$display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- compile.f
+incdir+tests
rtl/isa_pkg.sv
rtl/alu_pkg.sv
rtl/alu.sv
rtl/instr_decode.sv
rtl/reg_file.sv
rtl/exec_unit.sv
tests/exec_unit_tb.sv

//--- Makefile
# Verilator flow for the exec_unit testbench

VERILATOR ?= verilator
TOP       ?= exec_unit_tb
RTL_TOP   ?= exec_unit
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ** PASS **

.PHONY: all lint lint_rtl sim clean

all: sim

lint: lint_rtl
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

lint_rtl:
	$(VERILATOR) --lint-only rtl/isa_pkg.sv rtl/alu_pkg.sv rtl/alu.sv \
		rtl/instr_decode.sv rtl/reg_file.sv rtl/exec_unit.sv --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard rtl/*.sv) $(wildcard tests/*.sv tests/*.svh)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# fails unless the pass message shows up in the simulation output
sim: $(BUILD_DIR)/V$(TOP)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
